/* flist.f */
+incdir+source
source/exu_pkg.sv
source/load_store_unit.sv
source/store_queue.sv
source/dcache_arb.sv
source/exu_top.sv
test/exu_properties.sv
test/tb_exu_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_exu_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Passes only when the pass message shows up as a line of its own
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module tb_exu_top;

    import exu_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_LOADS  = 24;
    localparam int NUM_OPS    = NUM_LOADS + 16 + `SQ_DEPTH + 5;
    localparam logic [`XLEN-1:0] FILL_KEY = 64'h5a5a_0000_1234_8765;

    typedef struct packed {
        logic [`ROB_ID_W-1:0] robid;
        bus_req_t             req;
    } store_rec_t;

    logic                 clock;
    logic                 reset;
    logic                 mem_valid;
    logic                 mem_ready;
    mem_issue_t           mem_issue;
    logic                 disp_valid;
    logic [`ROB_ID_W-1:0] disp_robid;
    logic                 sq_can_alloc;
    logic [`SQ_ID_W-1:0]  sq_alloc_sqid;
    logic                 commit_valid;
    logic [`ROB_ID_W-1:0] commit_robid;
    logic                 memwb_valid;
    mem_wb_t              memwb;
    logic                 tbus_index_valid;
    logic                 tbus_index_ready = 1'b0;
    bus_req_t             tbus_req;
    logic [`XLEN-1:0]     tbus_read_data = '0;
    logic                 tbus_operation_done = 1'b0;

    integer               seed;
    int                   load_errors;
    int                   store_errors;
    int                   bus_errors = 0;
    int                   writes_committed;
    int                   writes_done = 0;
    logic [`ROB_ID_W-1:0] next_robid;

    // Reference memory follows commits
    logic [`XLEN-1:0]     ref_mem [logic [`XLEN-1:0]];
    // Bus memory follows the DUT writes
    logic [`XLEN-1:0]     bus_mem [logic [`XLEN-1:0]];
    store_rec_t           pending_q [$];
    bus_req_t             committed_q [$];

    logic                 bus_busy = 1'b0;
    int                   bus_wait;
    bus_req_t             bus_held;

    exu_top i_exu_top (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [`XLEN-1:0] ref_word(input logic [`XLEN-1:0] idx);
        return ref_mem.exists(idx) ? ref_mem[idx] : idx ^ FILL_KEY;
    endfunction

    function automatic logic [`XLEN-1:0] bus_word(input logic [`XLEN-1:0] idx);
        return bus_mem.exists(idx) ? bus_mem[idx] : idx ^ FILL_KEY;
    endfunction

    function automatic logic [`XLEN-1:0] rand_word();
        return {32'($random(seed)), 32'($random(seed))};
    endfunction

    // Random size-aligned address in the region picked by bit 40
    function automatic logic [`XLEN-1:0] rand_addr(input logic [1:0] size, input logic high);
        logic [`XLEN-1:0] a;
        a = rand_word();
        a[40] = high;
        a[2:0] = 3'($random(seed)) & (3'h7 << size);
        return a;
    endfunction

    function automatic logic [`XLEN-1:0] expect_load(input logic [`XLEN-1:0] word,
                                                     input logic [2:0] off,
                                                     input logic [1:0] size, input logic uns);
        int n;
        logic [`XLEN-1:0] val;
        n = 1 << size;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i*8 +: 8] = word[(off+i)*8 +: 8];
        end
        if (!uns && val[n*8-1]) begin
            for (int i = n; i < 8; i++) begin
                val[i*8 +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    // Byte lanes off .. off+n-1 carry the low bytes of the store data
    function automatic bus_req_t expect_write(input logic [`XLEN-1:0] addr,
                                              input logic [1:0] size,
                                              input logic [`XLEN-1:0] data);
        bus_req_t w;
        int n;
        n = 1 << size;
        w = '0;
        w.index = {addr[`XLEN-1:3], 3'b000};
        w.op = op_write;
        for (int i = 0; i < n; i++) begin
            w.write_mask[(addr[2:0]+i)*8 +: 8] = 8'hff;
            w.write_data[(addr[2:0]+i)*8 +: 8] = data[i*8 +: 8];
        end
        return w;
    endfunction

    function automatic void check_write(input bus_req_t got);
        bus_req_t exp;
        if (committed_q.size() == 0) begin
            bus_errors++;
            $display("** Error at %0t: bus write to index %h with no committed store",
                     $time, got.index);
        end else begin
            exp = committed_q.pop_front();
            assert (got.index == exp.index) else begin
                bus_errors++;
                $display("** Error at %0t: tbus_req.index expected %h got %h",
                         $time, exp.index, got.index);
            end
            assert (got.write_mask == exp.write_mask) else begin
                bus_errors++;
                $display("** Error at %0t: tbus_req.write_mask expected %h got %h",
                         $time, exp.write_mask, got.write_mask);
            end
            assert ((got.write_data & exp.write_mask) == exp.write_data) else begin
                bus_errors++;
                $display("** Error at %0t: tbus_req.write_data expected %h got %h",
                         $time, exp.write_data, got.write_data & exp.write_mask);
            end
        end
    endfunction

    // Bus memory with random stalls and a done 1 to 3 cycles after the transfer
    always @(negedge clock) begin
        tbus_operation_done = 1'b0;
        if (reset) begin
            bus_busy         = 1'b0;
            tbus_index_ready = 1'b0;
        end else if (bus_busy) begin
            tbus_index_ready = 1'b0;
            bus_wait = bus_wait - 1;
            if (bus_wait == 0) begin
                bus_busy            = 1'b0;
                tbus_operation_done = 1'b1;
                if (bus_held.op == op_write) begin
                    bus_mem[bus_held.index] = (bus_word(bus_held.index) & ~bus_held.write_mask)
                                              | (bus_held.write_data & bus_held.write_mask);
                    writes_done++;
                end else begin
                    tbus_read_data = bus_word(bus_held.index);
                end
            end
        end else begin
            tbus_index_ready = ($random(seed) & 3) != 0;
            if (tbus_index_valid && tbus_index_ready) begin
                bus_busy = 1'b1;
                bus_wait = 1 + ($unsigned($random(seed)) % 3);
                bus_held = tbus_req;
                if (tbus_req.op == op_write) begin
                    check_write(tbus_req);
                end
            end
        end
    end

    task automatic issue_op(input mem_issue_t op);
        @(negedge clock);
        while (!mem_ready) @(negedge clock);
        mem_valid = 1'b1;
        mem_issue = op;
        @(negedge clock);
        mem_valid = 1'b0;
    endtask

    task automatic build_op(input logic is_load, input logic [`ROB_ID_W-1:0] robid,
                            input logic [`XLEN-1:0] addr, input logic [1:0] size,
                            input logic uns, input logic [`XLEN-1:0] data,
                            input logic [`SQ_ID_W-1:0] sqid, output mem_issue_t op);
        logic [`XLEN-1:0] imm;
        imm = {55'd0, 6'($random(seed)), 3'b000};
        op = '0;
        op.robid       = robid;
        op.sqid        = sqid;
        op.prd         = 6'(robid);
        op.src1        = addr - imm;
        op.src2        = data;
        op.imm         = imm;
        op.is_load     = is_load;
        op.is_store    = !is_load;
        op.is_unsigned = uns;
        op.ls_size     = size;
    endtask

    task automatic do_load(input logic [`XLEN-1:0] addr, input logic [1:0] size,
                           input logic uns);
        mem_issue_t op;
        logic [`XLEN-1:0] exp;
        build_op(1'b1, next_robid, addr, size, uns, '0, '0, op);
        next_robid = next_robid + 1'b1;
        exp = expect_load(ref_word({addr[`XLEN-1:3], 3'b000}), addr[2:0], size, uns);
        issue_op(op);
        while (!memwb_valid) @(negedge clock);
        assert (memwb.result == exp) else begin
            load_errors++;
            $display("** Error at %0t: memwb.result expected %h got %h",
                     $time, exp, memwb.result);
        end
        assert (memwb.robid == op.robid) else begin
            load_errors++;
            $display("** Error at %0t: memwb.robid expected %h got %h",
                     $time, op.robid, memwb.robid);
        end
        assert (memwb.prd == op.prd) else begin
            load_errors++;
            $display("** Error at %0t: memwb.prd expected %h got %h",
                     $time, op.prd, memwb.prd);
        end
        assert (memwb.need_to_wb) else begin
            load_errors++;
            $display("** Error at %0t: memwb.need_to_wb expected 1 got %b",
                     $time, memwb.need_to_wb);
        end
    endtask

    // Dispatch allocation and issue with the granted queue index
    task automatic do_store(input logic [`XLEN-1:0] addr, input logic [1:0] size,
                            input logic [`XLEN-1:0] data);
        logic [`SQ_ID_W-1:0] sqid;
        mem_issue_t op;
        store_rec_t rec;
        @(negedge clock);
        while (!sq_can_alloc) @(negedge clock);
        disp_valid = 1'b1;
        disp_robid = next_robid;
        sqid = sq_alloc_sqid;
        rec.robid = next_robid;
        next_robid = next_robid + 1'b1;
        @(negedge clock);
        disp_valid = 1'b0;
        build_op(1'b0, rec.robid, addr, size, 1'b0, data, sqid, op);
        issue_op(op);
        rec.req = expect_write(addr, size, data);
        pending_q.push_back(rec);
        // Store writeback pulses in the cycle after the issue
        assert (memwb_valid) else begin
            store_errors++;
            $display("** Error at %0t: memwb_valid expected 1 got %b",
                     $time, memwb_valid);
        end
        assert (!memwb.need_to_wb) else begin
            store_errors++;
            $display("** Error at %0t: memwb.need_to_wb expected 0 got %b",
                     $time, memwb.need_to_wb);
        end
        assert (memwb.robid == rec.robid) else begin
            store_errors++;
            $display("** Error at %0t: memwb.robid expected %h got %h",
                     $time, rec.robid, memwb.robid);
        end
    endtask

    task automatic commit_oldest();
        store_rec_t rec;
        rec = pending_q.pop_front();
        @(negedge clock);
        commit_valid = 1'b1;
        commit_robid = rec.robid;
        committed_q.push_back(rec.req);
        ref_mem[rec.req.index] = (ref_word(rec.req.index) & ~rec.req.write_mask)
                                 | (rec.req.write_data & rec.req.write_mask);
        writes_committed++;
        @(negedge clock);
        commit_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (writes_done != writes_committed) @(negedge clock);
    endtask

    initial begin
        logic [`XLEN-1:0] addr;
        seed             = 32'ha8b3;
        clock            = 1'b0;
        reset            = 1'b1;
        mem_valid        = 1'b0;
        mem_issue        = '0;
        disp_valid       = 1'b0;
        disp_robid       = '0;
        commit_valid     = 1'b0;
        commit_robid     = '0;
        load_errors      = 0;
        store_errors     = 0;
        writes_committed = 0;
        next_robid       = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;

        for (int k = 0; k < NUM_LOADS; k++) begin
            do_load(rand_addr(2'(k), 1'b0), 2'(k), k[2]);
        end

        // Each store drains before a full-word load reads it back
        for (int k = 0; k < 8; k++) begin
            addr = rand_addr(2'(k), 1'b0);
            do_store(addr, 2'(k), rand_word());
            commit_oldest();
            wait_drain();
            do_load({addr[`XLEN-1:3], 3'b000}, 2'd3, 1'b0);
        end

        for (int k = 0; k < `SQ_DEPTH; k++) begin
            do_store(rand_addr(2'(k), 1'b0), 2'(k), rand_word());
        end
        for (int k = 0; k < `SQ_DEPTH; k++) begin
            commit_oldest();
        end
        wait_drain();

        // Load in the upper region while stores drain
        for (int k = 0; k < 4; k++) begin
            do_store(rand_addr(2'(k), 1'b0), 2'(k), rand_word());
        end
        for (int k = 0; k < 4; k++) begin
            commit_oldest();
        end
        do_load(rand_addr(2'd2, 1'b1), 2'd2, 1'b0);
        wait_drain();

        repeat (4) @(negedge clock);
        $display("Load errors: %0d, store writeback errors: %0d, bus write errors: %0d",
                 load_errors, store_errors, bus_errors);
        if (load_errors + store_errors + bus_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * 200 * NUM_OPS);
        $display("Timeout: the run did not finish within %0d cycles", 200 * NUM_OPS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* test/exu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_properties (
    input logic                clock,
    input logic                reset,
    input logic                mem_ready,
    input logic                disp_valid,
    input logic                sq_can_alloc,
    input logic [`SQ_ID_W-1:0] sq_alloc_sqid,
    input logic                memwb_valid,
    input logic                tbus_index_valid,
    input logic                tbus_index_ready,
    input exu_pkg::bus_req_t   tbus_req,
    input logic                tbus_operation_done
);

    import exu_pkg::*;

    logic              outstanding;
    logic              write_out;
    logic [`SQ_ID_W:0] occupancy;

    // Whole bytes in one naturally aligned run of 1, 2, 4 or 8
    function automatic logic mask_ok(input logic [`XLEN-1:0] mask);
        logic [7:0] bm;
        for (int i = 0; i < 8; i++) begin
            bm[i] = mask[i*8];
            if (mask[i*8 +: 8] != {8{bm[i]}}) begin
                return 1'b0;
            end
        end
        return bm inside {8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80,
                          8'h03, 8'h0c, 8'h30, 8'hc0, 8'h0f, 8'hf0, 8'hff};
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
            write_out   <= 1'b0;
            occupancy   <= '0;
        end else begin
            if (tbus_index_valid && tbus_index_ready) begin
                outstanding <= 1'b1;
                write_out   <= (tbus_req.op == op_write);
            end else if (tbus_operation_done) begin
                outstanding <= 1'b0;
            end
            // Entries live from allocation to the done of their write
            case ({disp_valid && sq_can_alloc, tbus_operation_done && write_out})
                2'b10:   occupancy <= occupancy + (`SQ_ID_W+1)'(1);
                2'b01:   occupancy <= occupancy - (`SQ_ID_W+1)'(1);
                default: occupancy <= occupancy;
            endcase
        end
    end

    assert property (@(posedge clock) reset |=> (mem_ready && sq_can_alloc
                     && sq_alloc_sqid == '0 && !memwb_valid && !tbus_index_valid))
        else $error("outputs not at their reset values after reset");

    assert property (@(posedge clock) disable iff (reset)
        tbus_index_valid && !tbus_index_ready |=> tbus_index_valid && $stable(tbus_req))
        else $error("bus request changed before it was accepted");

    assert property (@(posedge clock) disable iff (reset) outstanding |-> !tbus_index_valid)
        else $error("new bus request before the done of the previous one");

    assert property (@(posedge clock) disable iff (reset)
        tbus_index_valid && tbus_req.op == op_write |-> mask_ok(tbus_req.write_mask))
        else $error("bus write mask does not match an aligned access size");

    assert property (@(posedge clock) disable iff (reset)
        sq_can_alloc == (occupancy != (`SQ_ID_W+1)'(`SQ_DEPTH)))
        else $error("sq_can_alloc does not follow the store queue fill level");

    assert property (@(posedge clock) disable iff (reset)
        disp_valid && sq_can_alloc |=> sq_alloc_sqid == `SQ_ID_W'($past(sq_alloc_sqid) + 1))
        else $error("allocation index did not advance in order");

endmodule

bind exu_top exu_properties i_exu_properties (.*);

`default_nettype wire

/* source/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_top (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 mem_valid,
    output logic                 mem_ready,
    input  exu_pkg::mem_issue_t  mem_issue,

    input  logic                 disp_valid,
    input  logic [`ROB_ID_W-1:0] disp_robid,
    output logic                 sq_can_alloc,
    output logic [`SQ_ID_W-1:0]  sq_alloc_sqid,

    input  logic                 commit_valid,
    input  logic [`ROB_ID_W-1:0] commit_robid,

    output logic                 memwb_valid,
    output exu_pkg::mem_wb_t     memwb,

    output logic                 tbus_index_valid,
    input  logic                 tbus_index_ready,
    output exu_pkg::bus_req_t    tbus_req,
    input  logic [`XLEN-1:0]     tbus_read_data,
    input  logic                 tbus_operation_done
);

    import exu_pkg::*;

    // Load channel into the arbiter
    logic             ld_req_valid;
    logic             ld_req_ready;
    logic [`XLEN-1:0] ld_index;
    logic             ld_done;
    logic [`XLEN-1:0] ld_read_data;

    // Store queue channel into the arbiter
    logic             sq_req_valid;
    logic             sq_req_ready;
    bus_req_t         sq_req;
    logic             sq_done;

    sq_fill_t         sq_fill;

    load_store_unit u_load_store_unit (
        .clock        (clock),
        .reset        (reset),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_issue    (mem_issue),
        .ld_req_valid (ld_req_valid),
        .ld_req_ready (ld_req_ready),
        .ld_index     (ld_index),
        .ld_done      (ld_done),
        .ld_read_data (ld_read_data),
        .sq_fill      (sq_fill),
        .memwb_valid  (memwb_valid),
        .memwb        (memwb)
    );

    store_queue u_store_queue (
        .clock         (clock),
        .reset         (reset),
        .disp_valid    (disp_valid),
        .disp_robid    (disp_robid),
        .sq_can_alloc  (sq_can_alloc),
        .sq_alloc_sqid (sq_alloc_sqid),
        .sq_fill       (sq_fill),
        .commit_valid  (commit_valid),
        .commit_robid  (commit_robid),
        .sq_req_valid  (sq_req_valid),
        .sq_req_ready  (sq_req_ready),
        .sq_req        (sq_req),
        .sq_done       (sq_done)
    );

    dcache_arb u_dcache_arb (
        .clock               (clock),
        .reset               (reset),
        .ld_req_valid        (ld_req_valid),
        .ld_req_ready        (ld_req_ready),
        .ld_index            (ld_index),
        .ld_done             (ld_done),
        .ld_read_data        (ld_read_data),
        .sq_req_valid        (sq_req_valid),
        .sq_req_ready        (sq_req_ready),
        .sq_req              (sq_req),
        .sq_done             (sq_done),
        .tbus_index_valid    (tbus_index_valid),
        .tbus_index_ready    (tbus_index_ready),
        .tbus_req            (tbus_req),
        .tbus_read_data      (tbus_read_data),
        .tbus_operation_done (tbus_operation_done)
    );

endmodule

`default_nettype wire

/* source/dcache_arb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module dcache_arb (
    input  logic              clock,
    input  logic              reset,

    input  logic              ld_req_valid,
    output logic              ld_req_ready,
    input  logic [`XLEN-1:0]  ld_index,
    output logic              ld_done,
    output logic [`XLEN-1:0]  ld_read_data,

    input  logic              sq_req_valid,
    output logic              sq_req_ready,
    input  exu_pkg::bus_req_t sq_req,
    output logic              sq_done,

    output logic              tbus_index_valid,
    input  logic              tbus_index_ready,
    output exu_pkg::bus_req_t tbus_req,
    input  logic [`XLEN-1:0]  tbus_read_data,
    input  logic              tbus_operation_done
);

    import exu_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_LOAD,
        ARB_STORE
    } arb_state_t;

    arb_state_t state;

    // Grant is taken in idle and held until the done pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (ld_req_valid) begin
                        state <= ARB_LOAD;
                    end else if (sq_req_valid) begin
                        state <= ARB_STORE;
                    end
                end
                ARB_LOAD, ARB_STORE: begin
                    if (tbus_operation_done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        if (state == ARB_STORE) begin
            tbus_index_valid = sq_req_valid;
            tbus_req         = sq_req;
        end else begin
            tbus_index_valid    = (state == ARB_LOAD) && ld_req_valid;
            tbus_req.index      = ld_index;
            tbus_req.write_data = '0;
            tbus_req.write_mask = '0;
            tbus_req.op         = op_read;
        end
    end

    assign ld_req_ready = (state == ARB_LOAD) && tbus_index_ready;
    assign sq_req_ready = (state == ARB_STORE) && tbus_index_ready;
    assign ld_done      = (state == ARB_LOAD) && tbus_operation_done;
    assign sq_done      = (state == ARB_STORE) && tbus_operation_done;
    assign ld_read_data = tbus_read_data;

endmodule

`default_nettype wire

/* source/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module store_queue (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 disp_valid,
    input  logic [`ROB_ID_W-1:0] disp_robid,
    output logic                 sq_can_alloc,
    output logic [`SQ_ID_W-1:0]  sq_alloc_sqid,

    input  exu_pkg::sq_fill_t    sq_fill,

    input  logic                 commit_valid,
    input  logic [`ROB_ID_W-1:0] commit_robid,

    output logic                 sq_req_valid,
    input  logic                 sq_req_ready,
    output exu_pkg::bus_req_t    sq_req,
    input  logic                 sq_done
);

    import exu_pkg::*;

    logic [`SQ_ID_W-1:0]  head;
    logic [`SQ_ID_W-1:0]  tail;
    logic [`SQ_ID_W-1:0]  cmt;
    logic [`SQ_ID_W:0]    count;

    logic [`SQ_DEPTH-1:0] valid;
    logic [`SQ_DEPTH-1:0] filled;
    logic [`SQ_DEPTH-1:0] committed;
    logic                 req_sent;

    logic [`ROB_ID_W-1:0] robid_q [`SQ_DEPTH];
    logic [`XLEN-1:0]     addr_q  [`SQ_DEPTH];
    logic [`XLEN-1:0]     data_q  [`SQ_DEPTH];
    logic [`XLEN-1:0]     mask_q  [`SQ_DEPTH];

    logic                 do_alloc;
    logic                 do_commit;
    logic                 do_free;

    assign sq_can_alloc  = (count != (`SQ_ID_W+1)'(`SQ_DEPTH));
    assign sq_alloc_sqid = tail;

    assign do_alloc  = disp_valid && sq_can_alloc;
    // Only the oldest uncommitted store can match
    assign do_commit = commit_valid && valid[cmt] && !committed[cmt]
                       && (robid_q[cmt] == commit_robid);
    assign do_free   = sq_done && req_sent;

    assign sq_req_valid = valid[head] && filled[head] && committed[head] && !req_sent;

    always_comb begin
        sq_req.index      = {addr_q[head][`XLEN-1:3], 3'b000};
        sq_req.write_data = data_q[head];
        sq_req.write_mask = mask_q[head];
        sq_req.op         = op_write;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid     <= '0;
            filled    <= '0;
            committed <= '0;
            head      <= '0;
            tail      <= '0;
            cmt       <= '0;
            count     <= '0;
            req_sent  <= 1'b0;
        end else begin
            if (sq_req_valid && sq_req_ready) begin
                req_sent <= 1'b1;
            end

            // Head entry leaves once its write is done
            if (do_free) begin
                valid[head] <= 1'b0;
                req_sent    <= 1'b0;
                head        <= head + 1'b1;
            end

            if (do_alloc) begin
                valid[tail]     <= 1'b1;
                filled[tail]    <= 1'b0;
                committed[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end

            if (sq_fill.valid) begin
                filled[sq_fill.sqid] <= 1'b1;
            end

            if (do_commit) begin
                committed[cmt] <= 1'b1;
                cmt            <= cmt + 1'b1;
            end

            case ({do_alloc, do_free})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_alloc) begin
            robid_q[tail] <= disp_robid;
        end
        if (sq_fill.valid) begin
            addr_q[sq_fill.sqid] <= sq_fill.addr;
            data_q[sq_fill.sqid] <= sq_fill.data;
            mask_q[sq_fill.sqid] <= sq_fill.mask;
        end
    end

endmodule

`default_nettype wire

/* source/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module load_store_unit (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 mem_valid,
    output logic                 mem_ready,
    input  exu_pkg::mem_issue_t  mem_issue,

    output logic                 ld_req_valid,
    input  logic                 ld_req_ready,
    output logic [`XLEN-1:0]     ld_index,
    input  logic                 ld_done,
    input  logic [`XLEN-1:0]     ld_read_data,

    output exu_pkg::sq_fill_t    sq_fill,

    output logic                 memwb_valid,
    output exu_pkg::mem_wb_t     memwb
);

    import exu_pkg::*;

    logic [`XLEN-1:0]      addr;
    logic [2:0]            offset;
    logic                  load_take;
    logic                  store_take;
    logic [7:0]            byte_mask;
    logic [`XLEN-1:0]      store_mask;
    logic [`XLEN-1:0]      store_data;

    logic                  ld_busy;
    logic [`ROB_ID_W-1:0]  ld_robid;
    logic [`PREG_W-1:0]    ld_prd;
    logic [2:0]            ld_offset;
    logic [`LS_SIZE_W-1:0] ld_size;
    logic                  ld_unsigned;

    function automatic logic [7:0] size_bytes(input logic [`LS_SIZE_W-1:0] size);
        case (size)
            `LS_SIZE_B:   return 8'h01;
            `LS_SIZE_H:   return 8'h03;
            `LS_SIZE_W32: return 8'h0f;
            default:      return 8'hff;
        endcase
    endfunction

    // Shift the addressed bytes down and extend them
    function automatic logic [`XLEN-1:0] load_extract(
        input logic [`XLEN-1:0]      word,
        input logic [2:0]            off,
        input logic [`LS_SIZE_W-1:0] size,
        input logic                  is_unsigned
    );
        logic [`XLEN-1:0] sh;
        sh = word >> {off, 3'b000};
        case (size)
            `LS_SIZE_B:
                return is_unsigned ? {{(`XLEN-8){1'b0}}, sh[7:0]}
                                   : {{(`XLEN-8){sh[7]}}, sh[7:0]};
            `LS_SIZE_H:
                return is_unsigned ? {{(`XLEN-16){1'b0}}, sh[15:0]}
                                   : {{(`XLEN-16){sh[15]}}, sh[15:0]};
            `LS_SIZE_W32:
                return is_unsigned ? {{(`XLEN-32){1'b0}}, sh[31:0]}
                                   : {{(`XLEN-32){sh[31]}}, sh[31:0]};
            default:
                return sh;
        endcase
    endfunction

    assign addr       = mem_issue.src1 + mem_issue.imm;
    assign offset     = addr[2:0];
    assign mem_ready  = !ld_busy;
    assign load_take  = mem_valid && mem_ready && mem_issue.is_load;
    assign store_take = mem_valid && mem_ready && mem_issue.is_store;

    assign byte_mask  = size_bytes(mem_issue.ls_size) << offset;
    assign store_data = mem_issue.src2 << {offset, 3'b000};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            store_mask[i*8 +: 8] = {8{byte_mask[i]}};
        end
    end

    // Load control with one outstanding load at a time
    always_ff @(posedge clock) begin
        if (reset) begin
            ld_busy      <= 1'b0;
            ld_req_valid <= 1'b0;
        end else begin
            if (load_take) begin
                ld_busy      <= 1'b1;
                ld_req_valid <= 1'b1;
            end else if (ld_req_valid && ld_req_ready) begin
                ld_req_valid <= 1'b0;
            end
            if (ld_busy && ld_done) begin
                ld_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_take) begin
            ld_index    <= {addr[`XLEN-1:3], 3'b000};
            ld_robid    <= mem_issue.robid;
            ld_prd      <= mem_issue.prd;
            ld_offset   <= offset;
            ld_size     <= mem_issue.ls_size;
            ld_unsigned <= mem_issue.is_unsigned;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_fill.valid <= 1'b0;
        end else begin
            sq_fill.valid <= store_take;
            if (store_take) begin
                sq_fill.sqid <= mem_issue.sqid;
                sq_fill.addr <= addr;
                sq_fill.data <= store_data;
                sq_fill.mask <= store_mask;
            end
        end
    end

    // Writeback register
    always_ff @(posedge clock) begin
        if (reset) begin
            memwb_valid <= 1'b0;
        end else begin
            memwb_valid <= store_take || (ld_busy && ld_done);
        end
    end

    always_ff @(posedge clock) begin
        if (store_take) begin
            memwb.robid      <= mem_issue.robid;
            memwb.prd        <= mem_issue.prd;
            memwb.need_to_wb <= 1'b0;
            memwb.result     <= '0;
        end else if (ld_busy && ld_done) begin
            memwb.robid      <= ld_robid;
            memwb.prd        <= ld_prd;
            memwb.need_to_wb <= 1'b1;
            memwb.result     <= load_extract(ld_read_data, ld_offset, ld_size, ld_unsigned);
        end
    end

endmodule

`default_nettype wire

/* source/exu_pkg.sv */
`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_t;

    // One memory operation from issue
    typedef struct packed {
        logic [`ROB_ID_W-1:0]  robid;
        logic [`SQ_ID_W-1:0]   sqid;
        logic [`PREG_W-1:0]    prd;
        logic [`XLEN-1:0]      src1;
        logic [`XLEN-1:0]      src2;
        logic [`XLEN-1:0]      imm;
        logic                  is_load;
        logic                  is_store;
        logic                  is_unsigned;
        logic [`LS_SIZE_W-1:0] ls_size;
    } mem_issue_t;

    typedef struct packed {
        logic [`ROB_ID_W-1:0] robid;
        logic [`PREG_W-1:0]   prd;
        logic                 need_to_wb;
        logic [`XLEN-1:0]     result;
    } mem_wb_t;

    // Store address and aligned data into the queue
    typedef struct packed {
        logic                valid;
        logic [`SQ_ID_W-1:0] sqid;
        logic [`XLEN-1:0]    addr;
        logic [`XLEN-1:0]    data;
        logic [`XLEN-1:0]    mask;
    } sq_fill_t;

    typedef struct packed {
        logic [`XLEN-1:0] index;
        logic [`XLEN-1:0] write_data;
        logic [`XLEN-1:0] write_mask;
        bus_op_t          op;
    } bus_req_t;

endpackage

`default_nettype wire

/* source/exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// Data and address width
`define XLEN 64

// Reorder buffer id width
`define ROB_ID_W 7

// Physical register number width
`define PREG_W 6

// Store queue depth and the index width that matches it
`define SQ_DEPTH 8
`define SQ_ID_W 3

// Access size codes for byte, half, word and double
`define LS_SIZE_W 2
`define LS_SIZE_B 2'd0
`define LS_SIZE_H 2'd1
`define LS_SIZE_W32 2'd2
`define LS_SIZE_D 2'd3

`endif
